/* rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Integer register and datapath width
`define RV_XLEN 32

// Restoring divider retires one quotient bit per step
`define RV_DIV_STEPS `RV_XLEN

`endif

/* rv_isa_pkg.sv */
package rv_isa_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_t;

  // funct7 value selecting the M extension in OP
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // ALU selectors in funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Divide selectors with funct7 = F7_MULDIV
  localparam logic [2:0] F3_DIV  = 3'b100;
  localparam logic [2:0] F3_DIVU = 3'b101;
  localparam logic [2:0] F3_REM  = 3'b110;
  localparam logic [2:0] F3_REMU = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_t;

endpackage

/* rv_pipe_pkg.sv */
`include "rv_cfg.svh"

package rv_pipe_pkg;

  // One integer data word
  typedef logic [`RV_XLEN-1:0] xlen_t;

  // Architectural register number
  typedef logic [4:0] reg_idx_t;

  // Source of the value written by the EX/MEM register
  typedef enum logic [1:0] {
    // ALU output, also LUI through pass-b
    RES_ALU,
    // Divider quotient or remainder
    RES_DIV,
    // Link address of JAL
    RES_PC4
  } res_src_t;

endpackage

/* rv_alu.sv */
module rv_alu
  import rv_isa_pkg::*, rv_pipe_pkg::*;
(
  input  xlen_t   a,
  input  xlen_t   b,
  input  alu_op_t op,
  output xlen_t   result
);

  // Shift amount from the low bits of b
  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      // Set-less-than gives 0 or 1
      ALU_SLT:  result = xlen_t'($signed(a) < $signed(b));
      ALU_SLTU: result = xlen_t'(a < b);
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  result = xlen_t'($signed(a) >>> shamt);
      // LUI immediate goes straight through
      ALU_PASS_B: result = b;
      default:  result = '0;
    endcase
  end

endmodule

/* rv_branch_unit.sv */
module rv_branch_unit
  import rv_isa_pkg::*, rv_pipe_pkg::*;
(
  input  xlen_t      a,
  input  xlen_t      b,
  input  xlen_t      pc,
  input  xlen_t      imm,
  input  logic [2:0] funct3,
  input  logic       is_branch,
  input  logic       is_jump,
  output logic       redirect,
  output xlen_t      target
);

  logic taken;

  // Condition from funct3
  always_comb begin
    case (funct3)
      F3_BEQ:  taken = (a == b);
      F3_BNE:  taken = (a != b);
      F3_BLT:  taken = ($signed(a) < $signed(b));
      F3_BGE:  taken = ($signed(a) >= $signed(b));
      F3_BLTU: taken = (a < b);
      F3_BGEU: taken = (a >= b);
      // 010 and 011 are not branch encodings
      default: taken = 1'b0;
    endcase
  end

  // JAL always leaves the sequential path
  assign redirect = (is_branch && taken) || is_jump;

  // Shared PC-relative adder for branches and JAL
  assign target = pc + imm;

endmodule

/* rv_div.sv */
`include "rv_cfg.svh"

module rv_div
  import rv_pipe_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start,
  input  xlen_t dividend,
  input  xlen_t divisor,
  input  logic  is_signed,
  input  logic  want_rem,
  output logic  done,
  output xlen_t result
);

  localparam int XLEN  = $bits(xlen_t);
  localparam int CNT_W = $clog2(`RV_DIV_STEPS);

  typedef enum logic {
    DIV_IDLE,
    DIV_RUN
  } div_state_t;

  div_state_t       state;
  logic [CNT_W-1:0] step_cnt;

  // Partial remainder has one spare bit for the trial subtract
  logic [XLEN:0]    rem_q;
  xlen_t            quo_q;
  xlen_t            dsr_q;
  xlen_t            dvd_q;
  logic             neg_quo;
  logic             neg_rem;
  logic             div_zero;
  logic             rem_sel;

  xlen_t            dvd_mag;
  xlen_t            dsr_mag;
  logic [XLEN:0]    rem_in;
  xlen_t            quo_in;
  xlen_t            dsr_in;
  logic [XLEN:0]    rem_shift;
  logic [XLEN:0]    rem_trial;
  logic [XLEN:0]    rem_next;
  xlen_t            quo_next;
  xlen_t            quo_fix;
  xlen_t            rem_fix;

  // Magnitudes of signed operands
  assign dvd_mag = (is_signed && dividend[XLEN-1]) ? -dividend : dividend;
  assign dsr_mag = (is_signed && divisor[XLEN-1]) ? -divisor : divisor;

  // First step works on the fresh operands, so done lands N cycles after start
  assign rem_in = start ? '0 : rem_q;
  assign quo_in = start ? dvd_mag : quo_q;
  assign dsr_in = start ? dsr_mag : dsr_q;

  // One restoring step
  always_comb begin
    rem_shift = {rem_in[XLEN-1:0], quo_in[XLEN-1]};
    rem_trial = rem_shift - {1'b0, dsr_in};
    if (rem_trial[XLEN]) begin
      // Trial went negative, keep the shifted remainder
      rem_next = rem_shift;
      quo_next = {quo_in[XLEN-2:0], 1'b0};
    end else begin
      rem_next = rem_trial;
      quo_next = {quo_in[XLEN-2:0], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= DIV_IDLE;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        state    <= DIV_RUN;
        step_cnt <= CNT_W'(1);
      end else if (state == DIV_RUN) begin
        step_cnt <= step_cnt + 1'b1;
        // Last quotient bit on this edge
        if (step_cnt == CNT_W'(`RV_DIV_STEPS - 1)) begin
          state <= DIV_IDLE;
          done  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start || state == DIV_RUN) begin
      rem_q <= rem_next;
      quo_q <= quo_next;
    end
    if (start) begin
      dsr_q    <= dsr_mag;
      dvd_q    <= dividend;
      // Quotient sign from both operands, remainder follows the dividend
      neg_quo  <= is_signed && (dividend[XLEN-1] ^ divisor[XLEN-1]);
      neg_rem  <= is_signed && dividend[XLEN-1];
      div_zero <= (divisor == '0);
      rem_sel  <= want_rem;
    end
  end

  // Sign fix-up
  // Most negative over -1 wraps back to the dividend with zero remainder
  assign quo_fix = neg_quo ? -quo_q : quo_q;
  assign rem_fix = neg_rem ? -rem_q[XLEN-1:0] : rem_q[XLEN-1:0];

  // Divide by zero gives all ones and the dividend as remainder
  assign result = div_zero ? (rem_sel ? dvd_q : '1) : (rem_sel ? rem_fix : quo_fix);

endmodule

/* rv_stage_id.sv */
module rv_stage_id
  import rv_isa_pkg::*, rv_pipe_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  logic [31:0] instr,
  input  xlen_t       pc,
  input  xlen_t       rs1_data,
  input  xlen_t       rs2_data,
  output logic        id_valid,
  output alu_op_t     alu_op,
  output logic        alu_b_imm,
  output res_src_t    res_src,
  output logic        is_branch,
  output logic        is_jump,
  output logic        is_div,
  output logic [2:0]  funct3,
  output reg_idx_t    rd,
  output reg_idx_t    rs1,
  output reg_idx_t    rs2,
  output logic        we,
  output xlen_t       rs1_data_q,
  output xlen_t       rs2_data_q,
  output xlen_t       imm,
  output xlen_t       pc_q
);

  opcode_t    opcode;
  logic [2:0] f3;
  logic [6:0] f7;

  alu_op_t    dec_alu_op;
  logic       dec_b_imm;
  res_src_t   dec_res_src;
  logic       dec_branch;
  logic       dec_jump;
  logic       dec_div;
  logic       dec_we;
  xlen_t      dec_imm;

  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_b;
  xlen_t      imm_j;

  // alt picks SUB at 000 and SRA at 101
  function automatic alu_op_t alu_dec(input logic [2:0] sel, input logic alt);
    alu_op_t op;
    case (sel)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      default:    op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_t'(instr[6:0]);
  assign f3     = instr[14:12];
  assign f7     = instr[31:25];

  // Sign-extended immediates
  assign imm_i = xlen_t'($signed(instr[31:20]));
  assign imm_u = xlen_t'($signed({instr[31:12], 12'b0}));
  assign imm_b = xlen_t'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
  assign imm_j = xlen_t'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));

  always_comb begin
    dec_alu_op  = ALU_ADD;
    dec_b_imm   = 1'b0;
    dec_res_src = RES_ALU;
    dec_branch  = 1'b0;
    dec_jump    = 1'b0;
    dec_div     = 1'b0;
    dec_we      = 1'b0;
    dec_imm     = imm_i;
    case (opcode)
      OP: begin
        if (f7 == F7_MULDIV) begin
          // Only the divide half of M, multiplies retire with no write
          dec_div     = f3 inside {F3_DIV, F3_DIVU, F3_REM, F3_REMU};
          dec_we      = dec_div;
          dec_res_src = RES_DIV;
        end else begin
          dec_we     = 1'b1;
          dec_alu_op = alu_dec(f3, instr[30]);
        end
      end
      OP_IMM: begin
        dec_we     = 1'b1;
        dec_b_imm  = 1'b1;
        // Bit 30 is immediate data except for SRAI
        dec_alu_op = alu_dec(f3, instr[30] && (f3 == F3_SRL_SRA));
      end
      LUI: begin
        dec_we     = 1'b1;
        dec_b_imm  = 1'b1;
        dec_alu_op = ALU_PASS_B;
        dec_imm    = imm_u;
      end
      BRANCH: begin
        dec_branch = 1'b1;
        dec_imm    = imm_b;
      end
      JAL: begin
        dec_we      = 1'b1;
        dec_jump    = 1'b1;
        dec_res_src = RES_PC4;
        dec_imm     = imm_j;
      end
      // Unknown opcode still retires, with nothing written
      default: dec_we = 1'b0;
    endcase
  end

  // ID/EX control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_valid  <= 1'b0;
      we        <= 1'b0;
      is_branch <= 1'b0;
      is_jump   <= 1'b0;
      is_div    <= 1'b0;
    end else begin
      id_valid <= in_valid;
      if (in_valid) begin
        we        <= dec_we;
        is_branch <= dec_branch;
        is_jump   <= dec_jump;
        is_div    <= dec_div;
      end
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    if (in_valid) begin
      alu_op     <= dec_alu_op;
      alu_b_imm  <= dec_b_imm;
      res_src    <= dec_res_src;
      funct3     <= f3;
      rd         <= instr[11:7];
      rs1        <= instr[19:15];
      rs2        <= instr[24:20];
      rs1_data_q <= rs1_data;
      rs2_data_q <= rs2_data;
      imm        <= dec_imm;
      pc_q       <= pc;
    end
  end

endmodule

/* rv_stage_ex.sv */
module rv_stage_ex
  import rv_isa_pkg::*, rv_pipe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       id_valid,
  input  alu_op_t    alu_op,
  input  logic       alu_b_imm,
  input  res_src_t   res_src,
  input  logic       is_branch,
  input  logic       is_jump,
  input  logic       is_div,
  input  logic [2:0] funct3,
  input  reg_idx_t   rd,
  input  reg_idx_t   rs1,
  input  reg_idx_t   rs2,
  input  logic       we,
  input  xlen_t      rs1_data,
  input  xlen_t      rs2_data,
  input  xlen_t      imm,
  input  xlen_t      pc,
  output logic       res_valid,
  output logic       res_we,
  output reg_idx_t   res_rd,
  output xlen_t      res_data,
  output logic       redirect_valid,
  output xlen_t      redirect_pc,
  output logic       busy
);

  typedef enum logic {
    EX_IDLE,
    EX_EXEC
  } ex_state_t;

  ex_state_t state;
  ex_state_t state_next;

  xlen_t     fwd_rs1;
  xlen_t     fwd_rs2;
  xlen_t     alu_b;
  xlen_t     alu_result;
  logic      br_redirect;
  xlen_t     br_target;
  logic      div_start;
  logic      div_done;
  xlen_t     div_result;
  reg_idx_t  div_rd;
  logic      div_we;
  logic      single_done;
  res_src_t  wb_src;
  xlen_t     wb_data;
  xlen_t     pc_plus4;

  // Held EX/MEM result overrides the supplied data
  // x0 never forwards
  assign fwd_rs1 = (res_we && res_rd != '0 && rs1 == res_rd) ? res_data : rs1_data;
  assign fwd_rs2 = (res_we && res_rd != '0 && rs2 == res_rd) ? res_data : rs2_data;

  // Immediate forms replace rs2
  assign alu_b = alu_b_imm ? imm : fwd_rs2;

  rv_alu u_alu (
    .a      (fwd_rs1),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result)
  );

  rv_branch_unit u_branch (
    .a         (fwd_rs1),
    .b         (fwd_rs2),
    .pc        (pc),
    .imm       (imm),
    .funct3    (funct3),
    .is_branch (is_branch),
    .is_jump   (is_jump),
    .redirect  (br_redirect),
    .target    (br_target)
  );

  // Divide launches straight from ID/EX
  assign div_start = id_valid && is_div && (state == EX_IDLE);

  rv_div u_div (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (div_start),
    .dividend  (fwd_rs1),
    .divisor   (fwd_rs2),
    .is_signed (funct3 == F3_DIV || funct3 == F3_REM),
    .want_rem  (funct3 == F3_REM || funct3 == F3_REMU),
    .done      (div_done),
    .result    (div_result)
  );

  // IDLE to EXEC on a divide, back when the divider finishes
  always_comb begin
    state_next = state;
    case (state)
      EX_IDLE: if (div_start) state_next = EX_EXEC;
      EX_EXEC: if (div_done) state_next = EX_IDLE;
      default: state_next = EX_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= EX_IDLE;
      div_we <= 1'b0;
    end else begin
      state <= state_next;
      if (div_start) begin
        div_we <= we;
      end
    end
  end

  // Destination of the divide in flight
  always_ff @(posedge clk) begin
    if (div_start) begin
      div_rd <= rd;
    end
  end

  // Busy from the ID/EX divide until its result strobe
  assign busy = (id_valid && is_div) || (state == EX_EXEC);

  assign single_done = id_valid && !is_div;
  assign pc_plus4    = pc + xlen_t'(4);

  // Divider completion overrides the ID/EX source
  always_comb begin
    wb_src = div_done ? RES_DIV : res_src;
    case (wb_src)
      RES_DIV: wb_data = div_result;
      RES_PC4: wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid      <= 1'b0;
      res_we         <= 1'b0;
      res_rd         <= '0;
      redirect_valid <= 1'b0;
    end else begin
      res_valid      <= single_done || div_done;
      redirect_valid <= single_done && br_redirect;
      if (div_done) begin
        res_we <= div_we;
        res_rd <= div_rd;
      end else if (single_done) begin
        res_we <= we;
        res_rd <= rd;
      end
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    if (single_done || div_done) begin
      res_data <= wb_data;
    end
    if (single_done) begin
      redirect_pc <= br_target;
    end
  end

endmodule

/* rv_ex_top.sv */
module rv_ex_top
  import rv_isa_pkg::*, rv_pipe_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  logic [31:0] instr,
  input  xlen_t       pc,
  input  xlen_t       rs1_data,
  input  xlen_t       rs2_data,
  output logic        res_valid,
  output logic        res_we,
  output reg_idx_t    res_rd,
  output xlen_t       res_data,
  output logic        redirect_valid,
  output xlen_t       redirect_pc,
  output logic        busy
);

  // ID/EX register contents
  logic       id_valid;
  alu_op_t    id_alu_op;
  logic       id_alu_b_imm;
  res_src_t   id_res_src;
  logic       id_is_branch;
  logic       id_is_jump;
  logic       id_is_div;
  logic [2:0] id_funct3;
  reg_idx_t   id_rd;
  reg_idx_t   id_rs1;
  reg_idx_t   id_rs2;
  logic       id_we;
  xlen_t      id_rs1_data;
  xlen_t      id_rs2_data;
  xlen_t      id_imm;
  xlen_t      id_pc;

  rv_stage_id u_id (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .instr      (instr),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .id_valid   (id_valid),
    .alu_op     (id_alu_op),
    .alu_b_imm  (id_alu_b_imm),
    .res_src    (id_res_src),
    .is_branch  (id_is_branch),
    .is_jump    (id_is_jump),
    .is_div     (id_is_div),
    .funct3     (id_funct3),
    .rd         (id_rd),
    .rs1        (id_rs1),
    .rs2        (id_rs2),
    .we         (id_we),
    .rs1_data_q (id_rs1_data),
    .rs2_data_q (id_rs2_data),
    .imm        (id_imm),
    .pc_q       (id_pc)
  );

  rv_stage_ex u_ex (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_valid       (id_valid),
    .alu_op         (id_alu_op),
    .alu_b_imm      (id_alu_b_imm),
    .res_src        (id_res_src),
    .is_branch      (id_is_branch),
    .is_jump        (id_is_jump),
    .is_div         (id_is_div),
    .funct3         (id_funct3),
    .rd             (id_rd),
    .rs1            (id_rs1),
    .rs2            (id_rs2),
    .we             (id_we),
    .rs1_data       (id_rs1_data),
    .rs2_data       (id_rs2_data),
    .imm            (id_imm),
    .pc             (id_pc),
    .res_valid      (res_valid),
    .res_we         (res_we),
    .res_rd         (res_rd),
    .res_data       (res_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .busy           (busy)
  );

endmodule

/* tb_rv_ex.sv */
`include "rv_cfg.svh"

module tb_rv_ex
  import rv_pipe_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DIV_N = `RV_DIV_STEPS;

  logic clk, rst_n, in_valid;
  logic [31:0] instr;
  xlen_t pc, rs1_data, rs2_data, res_data, redirect_pc;
  logic res_valid, res_we, redirect_valid, busy;
  reg_idx_t res_rd;

  integer seed;
  int cyc = 0, rd_ptr = 0, wr_ptr = 0;
  int err_spur = 0, err_data = 0, err_redir = 0, err_lat = 0, err_busy = 0;
  int err_tmo = 0;

  // Architectural state without the newest write held in last_*
  logic [31:0] rf [32];
  logic last_we;
  logic [4:0] last_rd;
  logic [31:0] last_data;

  // Expected results in issue order
  logic exp_we [512], exp_redir [512], exp_div [512];
  logic [4:0] exp_rd [512];
  logic [31:0] exp_data [512], exp_rpc [512];
  int exp_cyc [512];

  logic h_we, h_redir, h_div, pend;
  logic [4:0] h_rd;
  logic [31:0] h_data, h_rpc;
  int h_cyc;

  rv_ex_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  assign pend    = (rd_ptr != wr_ptr);
  assign h_we    = exp_we[rd_ptr];
  assign h_redir = exp_redir[rd_ptr];
  assign h_div   = exp_div[rd_ptr];
  assign h_rd    = exp_rd[rd_ptr];
  assign h_data  = exp_data[rd_ptr];
  assign h_rpc   = exp_rpc[rd_ptr];
  assign h_cyc   = exp_cyc[rd_ptr];

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (res_valid) rd_ptr <= rd_ptr + 1;
  end

  // No strobe without an outstanding instruction
  a_spur: assert property (@(posedge clk) disable iff (!rst_n) res_valid |-> pend)
    else begin
      $display("Unexpected result strobe at %0t with nothing issued", $time);
      err_spur++;
    end

  a_data: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && pend) |-> (res_we == h_we && (!h_we || (res_rd == h_rd && res_data == h_data))))
    else begin
      $display("FAILED %0t: rd=%0d we=%b data=%h, expected rd=%0d we=%b data=%h",
               $time, res_rd, res_we, res_data, h_rd, h_we, h_data);
      err_data++;
    end

  a_redir: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && pend) |-> (redirect_valid == h_redir && (!h_redir || redirect_pc == h_rpc)))
    else begin
      $display("FAILED %0t: redirect %b pc %h, expected %b pc %h",
               $time, redirect_valid, redirect_pc, h_redir, h_rpc);
      err_redir++;
    end

  // Result arrives exactly at the issue-based cycle
  a_lat: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && pend) |-> (cyc == h_cyc))
    else begin
      $display("FAILED %0t: result in cycle %0d, expected cycle %0d", $time, cyc, h_cyc);
      err_lat++;
    end

  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (pend && h_div && cyc >= h_cyc - DIV_N - 1 && cyc < h_cyc) |-> busy)
    else begin
      $display("FAILED %0t: busy low while a divide runs", $time);
      err_busy++;
    end

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] div_ref(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
    logic sgn;
    logic rem;
    sgn = !f3[0];
    rem = f3[1];
    // Zero divisor and signed overflow per the M extension
    if (b == 32'd0) return rem ? a : 32'hffffffff;
    if (sgn && a == 32'h80000000 && b == 32'hffffffff) return rem ? 32'd0 : a;
    if (sgn) return rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
    return rem ? a % b : a / b;
  endfunction

  function automatic logic [31:0] reg_value(input logic [4:0] r);
    if (r == 5'd0) return 32'd0;
    if (last_we && last_rd == r) return last_data;
    return rf[r];
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] i, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {i[12], i[10:5], rs2, rs1, f3, i[4:1], i[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] i, input logic [4:0] rd);
    return {i[20], i[10:1], i[11], i[19:12], rd, 7'b1101111};
  endfunction

  // Model the instruction and present it on the next edge
  task automatic issue(input logic [31:0] ins);
    logic [31:0] a, b, d, pcv, rpc;
    logic we, redir, dv;
    logic [2:0] f3;
    pcv = $random(seed) & 32'hfffffffc;
    f3 = ins[14:12];
    a = reg_value(ins[19:15]);
    b = reg_value(ins[24:20]);
    we = 1'b1;
    redir = 1'b0;
    dv = 1'b0;
    rpc = 32'd0;
    d = 32'd0;
    case (ins[6:0])
      7'b0110011: begin
        dv = (ins[31:25] == 7'b0000001);
        d = dv ? div_ref(f3, a, b) : alu_ref(f3, ins[30], a, b);
      end
      7'b0010011: d = alu_ref(f3, ins[30] && f3 == 3'd5, a, {{20{ins[31]}}, ins[31:20]});
      7'b0110111: d = {ins[31:12], 12'd0};
      7'b1100011: begin
        we = 1'b0;
        case (f3)
          3'd0: redir = (a == b);
          3'd1: redir = (a != b);
          3'd4: redir = ($signed(a) < $signed(b));
          3'd5: redir = ($signed(a) >= $signed(b));
          3'd6: redir = (a < b);
          default: redir = (a >= b);
        endcase
        rpc = pcv + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      default: begin
        d = pcv + 32'd4;
        redir = 1'b1;
        rpc = pcv + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
    endcase
    @(posedge clk);
    in_valid <= 1'b1;
    instr <= ins;
    pc <= pcv;
    // Supplied data misses the preceding write
    rs1_data <= rf[ins[19:15]];
    rs2_data <= rf[ins[24:20]];
    exp_we[wr_ptr] = we;
    exp_rd[wr_ptr] = ins[11:7];
    exp_data[wr_ptr] = d;
    exp_redir[wr_ptr] = redir;
    exp_rpc[wr_ptr] = rpc;
    exp_div[wr_ptr] = dv;
    exp_cyc[wr_ptr] = cyc + 3 + (dv ? DIV_N : 0);
    wr_ptr = wr_ptr + 1;
    if (last_we) rf[last_rd] = last_data;
    last_we = we && ins[11:7] != 5'd0;
    last_rd = ins[11:7];
    last_data = d;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(posedge clk);
    in_valid <= 1'b0;
    while ((pend || busy) && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (pend || busy) begin
      $display("Timed out waiting for results to drain and busy to fall");
      err_tmo++;
    end
  endtask

  logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  logic [2:0] f3r;
  logic [4:0] ra, rb;

  initial begin
    seed = 32'h145a;
    rst_n = 1'b0;
    in_valid = 1'b0;
    instr = 32'd0;
    pc = '0;
    rs1_data = '0;
    rs2_data = '0;
    last_we = 1'b0;
    last_rd = 5'd0;
    last_data = 32'd0;
    for (int r = 0; r < 32; r++) rf[r] = 32'd0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // Idle after reset with no strobe expected
    repeat (6) @(posedge clk);
    // Fill registers with LUI and a dependent ADDI
    for (int r = 1; r < 32; r++) begin
      issue({$random(seed)} & 32'hfffff000 | {20'd0, 5'(r), 7'b0110111});
      issue(enc_i(12'($random(seed)), 5'(r), 3'd0, 5'(r)));
    end
    // Random back-to-back ALU and LUI
    for (int i = 0; i < 60; i++) begin
      f3r = 3'($random(seed));
      ra = 5'($random(seed));
      rb = 5'($random(seed));
      case ({$random(seed)} % 3)
        0: issue(enc_r((f3r == 3'd0 || f3r == 3'd5) ? {1'b0, 1'($random(seed)), 5'd0} : 7'd0,
                       rb, ra, f3r, 5'($random(seed))));
        1: begin
          if (f3r == 3'd1 || f3r == 3'd5)
            issue(enc_i({1'b0, f3r == 3'd5 && 1'($random(seed)), 5'd0, rb}, ra, f3r,
                        5'($random(seed))));
          else
            issue(enc_i(12'($random(seed)), ra, f3r, 5'($random(seed))));
        end
        default: issue({$random(seed)} & 32'hfffff000 | {20'd0, rb, 7'b0110111});
      endcase
    end
    // Dependent chain on x7 and x8
    for (int i = 0; i < 6; i++) begin
      issue(enc_i(12'd5, 5'd7, 3'd0, 5'd7));
      issue(enc_r(7'd0, 5'd7, 5'd8, 3'd0, 5'd8));
    end
    // x0 is never a forwarding source
    issue(enc_i(12'd123, 5'd5, 3'd0, 5'd0));
    issue(enc_r(7'd0, 5'd0, 5'd0, 3'd6, 5'd9));
    // Every branch condition with equal operands in half the cases
    for (int f = 0; f < 6; f++) begin
      for (int k = 0; k < 4; k++) begin
        ra = 5'($random(seed));
        rb = k[0] ? ra : 5'($random(seed));
        issue(enc_b({12'($random(seed)), 1'b0}, rb, ra, br_f3[f]));
      end
    end
    for (int k = 0; k < 4; k++) issue(enc_j({20'($random(seed)), 1'b0}, 5'($random(seed))));
    wait_drain();
    // Divides on corner and random operands
    issue({12'h800, 8'd0, 5'd20, 7'b0110111});
    issue(enc_i(12'hfff, 5'd0, 3'd0, 5'd21));
    wait_drain();
    for (int f = 4; f < 8; f++) begin
      issue(enc_r(7'd1, 5'd21, 5'd20, 3'(f), 5'd22));
      wait_drain();
      issue(enc_r(7'd1, 5'd0, 5'd3, 3'(f), 5'd23));
      wait_drain();
      for (int k = 0; k < 4; k++) begin
        issue(enc_r(7'd1, 5'($random(seed)), 5'($random(seed)), 3'(f), 5'($random(seed))));
        wait_drain();
      end
    end
    // Divide result forwarded to a dependent ADD
    issue(enc_r(7'd1, 5'd4, 5'd6, 3'd5, 5'd12));
    wait_drain();
    issue(enc_r(7'd0, 5'd12, 5'd12, 3'd0, 5'd13));
    wait_drain();
    repeat (3) @(posedge clk);
    $display("Errors: spurious=%0d data=%0d redirect=%0d latency=%0d busy=%0d timeout=%0d",
             err_spur, err_data, err_redir, err_lat, err_busy, err_tmo);
    if (err_spur + err_data + err_redir + err_lat + err_busy + err_tmo == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_alu.sv
rv_branch_unit.sv
rv_div.sv
rv_stage_id.sv
rv_stage_ex.sv
rv_ex_top.sv
tb_rv_ex.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, then search the log for the fail message
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_rv_ex \
  -o sim_tb_rv_ex > build.log 2>&1 \
  && ./obj_dir/sim_tb_rv_ex > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "Test failed" sim.log \
  && grep -q "Test passed" sim.log \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
